//--- verilog/ig_pkg.sv
package ig_pkg;

    // ------------------------------------------------------------------------
    // image geometry
    // ------------------------------------------------------------------------

    // pixels per row, square image
    localparam int IMG_W   = 256;
    // pixels per image
    localparam int IMG_PIX = IMG_W * IMG_W;
    // gradient word width, gx and gy halves
    localparam int GRAD_W  = 20;

    // ctrl phase encodings
    localparam int PH_W = 3;
    localparam logic [PH_W-1:0] PH_IDLE  = 3'd0;
    localparam logic [PH_W-1:0] PH_READ  = 3'd1;
    localparam logic [PH_W-1:0] PH_FLUSH = 3'd2;
    localparam logic [PH_W-1:0] PH_DRAIN = 3'd3;
    localparam logic [PH_W-1:0] PH_FIN   = 3'd4;

    // ------------------------------------------------------------------------
    // data types
    // ------------------------------------------------------------------------

    // one 8-bit unsigned pixel
    typedef logic [7:0] pix_t;
    // raster index, row in the upper byte and column in the lower byte
    typedef logic [15:0] pix_idx_t;
    // signed first difference
    typedef logic signed [9:0] grad_comp_t;

    // gx sits in the upper half
    typedef struct packed {
        grad_comp_t gx;
        grad_comp_t gy;
    } grad_pair_s;

    // raw bits on the memory port, pair for the arithmetic
    typedef union packed {
        logic [GRAD_W-1:0] raw;
        grad_pair_s        pair;
    } grad_word_u;

endpackage

//--- verilog/ig_ifs.sv
`timescale 1ns/10ps

// ----------------------------------------------------------------------------
// read requests, ctrl to fetch
// ----------------------------------------------------------------------------
interface ig_req_if import ig_pkg::*; ();
    logic     valid;
    logic     ready;
    pix_idx_t idx;
    // dummy pixel request for the final row windows
    logic     flush;

    modport source (output valid, idx, flush, input ready);
    modport sink   (input valid, idx, flush, output ready);
endinterface

// ----------------------------------------------------------------------------
// pixel stream, fetch to line buffer
// ----------------------------------------------------------------------------
interface ig_pix_if import ig_pkg::*; ();
    logic     valid;
    logic     ready;
    pix_t     pix;
    pix_idx_t idx;
    logic     flush;

    modport source (output valid, pix, idx, flush, input ready);
    modport sink   (input valid, pix, idx, flush, output ready);
endinterface

// ----------------------------------------------------------------------------
// pixel windows, line buffer to gradient unit
// ----------------------------------------------------------------------------
interface ig_win_if import ig_pkg::*; ();
    logic     valid;
    logic     ready;
    pix_t     base;
    // neighbor one column to the right
    pix_t     right;
    // neighbor one row down
    pix_t     below;
    pix_idx_t base_idx;

    modport source (output valid, base, right, below, base_idx, input ready);
    modport sink   (input valid, base, right, below, base_idx, output ready);
endinterface

//--- verilog/ig_ctrl.sv
`timescale 1ns/10ps

module ig_ctrl import ig_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    ig_req_if.source     req,
    input  logic         wr_fire,
    output logic         done
);

    logic [PH_W-1:0] phase;
    // accepted requests, wraps from read into flush numbering
    pix_idx_t        req_cnt;
    // completed gradient writes
    pix_idx_t        wr_cnt;
    logic            req_fire;

    assign req_fire  = req.valid && req.ready;

    // valid and idx only move on a transfer
    assign req.valid = (phase == PH_READ) || (phase == PH_FLUSH);
    assign req.flush = (phase == PH_FLUSH);
    assign req.idx   = req_cnt;

    assign done      = (phase == PH_FIN);

    // ------------------------------------------------------------------------
    // phase sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= PH_IDLE;
            req_cnt <= '0;
            wr_cnt  <= '0;
        end else begin
            if (req_fire) begin
                req_cnt <= req_cnt + 1'b1;
            end
            // writes start long before the drain phase
            if (wr_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            case (phase)
                PH_IDLE: begin
                    phase <= PH_READ;
                end
                PH_READ: begin
                    // last pixel read, counter wraps to flush 0
                    if (req_fire && req_cnt == pix_idx_t'(IMG_PIX - 1)) begin
                        phase <= PH_FLUSH;
                    end
                end
                PH_FLUSH: begin
                    // one flush per last-row pixel
                    if (req_fire && req_cnt == pix_idx_t'(IMG_W - 1)) begin
                        phase <= PH_DRAIN;
                    end
                end
                PH_DRAIN: begin
                    if (wr_fire && wr_cnt == pix_idx_t'(IMG_PIX - 1)) begin
                        phase <= PH_FIN;
                    end
                end
                PH_FIN: begin
                    phase <= PH_FIN;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // nothing requested and nothing written once the frame is complete
    a_quiet_after_done: assert property (@(posedge clk) disable iff (reset)
        done |-> !req.valid && !wr_fire);

endmodule

//--- verilog/ig_fetch.sv
`timescale 1ns/10ps

module ig_fetch import ig_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    ig_req_if.sink       req,
    ig_pix_if.source     pix_out,
    output logic         img_rd,
    output pix_idx_t     img_addr,
    input  pix_t         img_di
);

    // accepted request waiting for its memory data
    logic     inflight;
    pix_idx_t pend_idx;
    logic     pend_flush;

    // two entry queue
    pix_t     q_pix   [2];
    pix_idx_t q_idx   [2];
    logic     q_flush [2];
    logic     wr_ptr;
    logic     rd_ptr;
    logic [1:0] q_cnt;

    logic     req_fire;
    logic     pop;

    // room counts the entry still in flight
    assign req.ready = (q_cnt + {1'b0, inflight}) < 2'd2;
    assign req_fire  = req.valid && req.ready;

    // reads go out in the accept cycle, flushes never touch memory
    assign img_rd    = req_fire && !req.flush;
    assign img_addr  = req.idx;

    assign pop           = pix_out.valid && pix_out.ready;
    assign pix_out.valid = (q_cnt != 2'd0);
    assign pix_out.pix   = q_pix[rd_ptr];
    assign pix_out.idx   = q_idx[rd_ptr];
    assign pix_out.flush = q_flush[rd_ptr];

    // ------------------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            inflight <= 1'b0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            q_cnt    <= 2'd0;
        end else begin
            inflight <= req_fire;
            if (inflight) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            q_cnt <= q_cnt + {1'b0, inflight} - {1'b0, pop};
        end
    end

    // request tag and queue payload
    always_ff @(posedge clk) begin
        pend_idx   <= req.idx;
        pend_flush <= req.flush;
        if (inflight) begin
            // img_di lands one cycle after img_rd
            q_pix[wr_ptr]   <= pend_flush ? '0 : img_di;
            q_idx[wr_ptr]   <= pend_idx;
            q_flush[wr_ptr] <= pend_flush;
        end
    end

    // the returning pixel always finds a free slot
    a_room_for_read: assert property (@(posedge clk) disable iff (reset)
        img_rd |=> (q_cnt != 2'd2) || pop);

endmodule

//--- verilog/ig_line_buf.sv
`timescale 1ns/10ps

module ig_line_buf import ig_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    ig_pix_if.sink       pix_in,
    ig_win_if.source     win
);

    localparam int SLOT_W = $clog2(IMG_W);

    // last IMG_W real pixels
    pix_t              ring [IMG_W];
    logic [SLOT_W-1:0] slot;
    logic [SLOT_W-1:0] slot_right;
    logic              in_fire;
    logic              make_win;

    // stall the input while a window waits downstream
    assign pix_in.ready = !win.valid || win.ready;
    assign in_fire      = pix_in.valid && pix_in.ready;

    // low bits of idx pick the slot
    assign slot       = pix_in.idx[SLOT_W-1:0];
    assign slot_right = slot + 1'b1;

    // first row only fills the ring
    assign make_win = pix_in.flush || (pix_in.idx >= pix_idx_t'(IMG_W));

    // ------------------------------------------------------------------------
    // window output
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            win.valid <= 1'b0;
        end else if (in_fire && make_win) begin
            win.valid <= 1'b1;
        end else if (win.ready) begin
            win.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire && make_win) begin
            // slot still holds the pixel one row up
            win.base     <= ring[slot];
            // next slot not yet overwritten
            win.right    <= ring[slot_right];
            win.below    <= pix_in.pix;
            // flush k maps onto last row pixel k
            win.base_idx <= pix_in.idx - pix_idx_t'(IMG_W);
        end
    end

    // ring write, dummy pixels stay out
    always_ff @(posedge clk) begin
        if (in_fire && !pix_in.flush) begin
            ring[slot] <= pix_in.pix;
        end
    end

endmodule

//--- verilog/ig_grad_unit.sv
`timescale 1ns/10ps

module ig_grad_unit import ig_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    ig_win_if.sink       win,
    output logic         grad_wr,
    output pix_idx_t     grad_addr,
    output grad_word_u   grad_do,
    input  logic         grad_gnt,
    output logic         wr_fire
);

    grad_word_u grad_nxt;
    // last column or last row
    logic       edge_pix;
    logic       win_fire;

    assign wr_fire  = grad_wr && grad_gnt;

    // free slot, or the held word leaves this cycle
    assign win.ready = !grad_wr || grad_gnt;
    assign win_fire  = win.valid && win.ready;

    assign edge_pix = (win.base_idx[7:0] == 8'hff) || (win.base_idx[15:8] == 8'hff);

    // ------------------------------------------------------------------------
    // difference arithmetic
    // ------------------------------------------------------------------------
    always_comb begin
        // zero extend before subtracting, range -255 to 255
        grad_nxt.pair.gx = grad_comp_t'({2'b00, win.right}) - grad_comp_t'({2'b00, win.base});
        grad_nxt.pair.gy = grad_comp_t'({2'b00, win.below}) - grad_comp_t'({2'b00, win.base});
        if (edge_pix) begin
            grad_nxt.raw = '0;
        end
    end

    // ------------------------------------------------------------------------
    // memory write port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
        end else if (win_fire) begin
            grad_wr <= 1'b1;
        end else if (grad_gnt) begin
            grad_wr <= 1'b0;
        end
    end

    // word and address held until granted
    always_ff @(posedge clk) begin
        if (win_fire) begin
            grad_addr <= win.base_idx;
            grad_do   <= grad_nxt;
        end
    end

    // a refused write repeats unchanged
    a_hold_write: assert property (@(posedge clk) disable iff (reset)
        grad_wr && !grad_gnt |=> grad_wr && $stable(grad_do) && $stable(grad_addr));

endmodule

//--- verilog/ig_top.sv
`timescale 1ns/10ps

module ig_top import ig_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    // image memory read port
    output logic              img_rd,
    output pix_idx_t          img_addr,
    input  pix_t              img_di,
    // gradient memory write port
    output logic              grad_wr,
    output pix_idx_t          grad_addr,
    output logic [GRAD_W-1:0] grad_do,
    input  logic              grad_gnt,
    output logic              done
);

    ig_req_if req_if ();
    ig_pix_if pix_if ();
    ig_win_if win_if ();

    grad_word_u grad_word;
    logic       wr_fire;

    // memory sees the plain word
    assign grad_do = grad_word.raw;

    // ------------------------------------------------------------------------
    // request sequencing and completion
    // ------------------------------------------------------------------------
    ig_ctrl u_ctrl (
        .clk     (clk),
        .reset   (reset),
        .req     (req_if),
        .wr_fire (wr_fire),
        .done    (done)
    );

    // image reads into the pixel queue
    ig_fetch u_fetch (
        .clk      (clk),
        .reset    (reset),
        .req      (req_if),
        .pix_out  (pix_if),
        .img_rd   (img_rd),
        .img_addr (img_addr),
        .img_di   (img_di)
    );

    ig_line_buf u_line_buf (
        .clk    (clk),
        .reset  (reset),
        .pix_in (pix_if),
        .win    (win_if)
    );

    // differences and the gradient write port
    ig_grad_unit u_grad_unit (
        .clk       (clk),
        .reset     (reset),
        .win       (win_if),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_word),
        .grad_gnt  (grad_gnt),
        .wr_fire   (wr_fire)
    );

endmodule

//--- dv/ig_tb.sv
`timescale 1ns/10ps

module ig_tb import ig_pkg::*; ();

    // generous cycle budget for one frame at three quarters grant
    localparam int DONE_LIMIT = 8 * IMG_PIX;
    // cycles watched after done to see it stay high
    localparam int TAIL_CYCLES = 16;

    logic              clk;
    logic              reset;
    logic              img_rd;
    pix_idx_t          img_addr;
    pix_t              img_di;
    logic              grad_wr;
    pix_idx_t          grad_addr;
    logic [GRAD_W-1:0] grad_do;
    logic              grad_gnt;
    logic              done;

    // image memory contents and read pipeline
    pix_t       img_mem [IMG_PIX];
    logic       rd_q;
    pix_idx_t   addr_q;
    integer     seed;

    // checker state
    int         wr_count = 0;
    int         rd_count = 0;
    logic       reset_q = 1'b0;
    logic       hold_pend = 1'b0;
    pix_idx_t   held_addr;
    grad_word_u held_word;
    grad_word_u got_word;

    ig_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .grad_gnt  (grad_gnt),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // memory models
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        rd_q   <= img_rd;
        addr_q <= img_addr;
    end

    // data shows up for the next rising edge
    always @(negedge clk) begin
        if (rd_q) begin
            img_di <= img_mem[addr_q];
        end
    end

    // grant high about three cycles in four
    always @(negedge clk) begin
        grad_gnt <= ($random(seed) & 3) != 0;
    end

    // ------------------------------------------------------------------------
    // reference and compare helpers
    // ------------------------------------------------------------------------
    function automatic grad_word_u ref_grad(input pix_idx_t idx);
        grad_word_u w;
        int         i;
        int         here;
        i     = int'(idx);
        w.raw = '0;
        // last column and last row stay zero
        if ((i % IMG_W) != IMG_W - 1 && (i / IMG_W) != IMG_W - 1) begin
            here      = int'(img_mem[i]);
            w.pair.gx = grad_comp_t'(int'(img_mem[i + 1]) - here);
            w.pair.gy = grad_comp_t'(int'(img_mem[i + IMG_W]) - here);
        end
        return w;
    endfunction

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string name, input pix_idx_t got, input pix_idx_t exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                $time, name, got, exp));
        end
    endtask

    task automatic check_grad(input string name, input grad_word_u got,
                              input grad_word_u exp);
        if (got.raw !== exp.raw) begin
            fail_now($sformatf("Mismatch at %0t: %s got %h (%0d,%0d) expected %h (%0d,%0d)",
                $time, name, got.raw, got.pair.gx, got.pair.gy,
                exp.raw, exp.pair.gx, exp.pair.gy));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch at %0t: done got %b expected %b",
                $time, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // checker, one pass per rising edge
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        got_word.raw = grad_do;
        // quiet outputs while reset holds and one cycle after
        if (reset_q) begin
            check_flag("img_rd", img_rd, 1'b0);
            check_flag("grad_wr", grad_wr, 1'b0);
            check_done(done, 1'b0);
        end
        if (reset) begin
            wr_count  = 0;
            rd_count  = 0;
            hold_pend = 1'b0;
        end else begin
            check_done(done, wr_count == IMG_PIX);
            // image reads go out once each, in raster order
            if (img_rd) begin
                if (rd_count >= IMG_PIX) begin
                    fail_now($sformatf("an image read at %0t came after the last pixel",
                        $time));
                end else begin
                    check_addr("img_addr", img_addr, pix_idx_t'(rd_count));
                    rd_count++;
                end
            end
            // refused write must come back unchanged
            if (hold_pend) begin
                check_flag("grad_wr", grad_wr, 1'b1);
                check_addr("grad_addr", grad_addr, held_addr);
                check_grad("grad_do", got_word, held_word);
            end
            if (grad_wr && grad_gnt) begin
                if (wr_count >= IMG_PIX) begin
                    fail_now($sformatf("a write at %0t came after the last address", $time));
                end else begin
                    check_addr("grad_addr", grad_addr, pix_idx_t'(wr_count));
                    check_grad("grad_do", got_word, ref_grad(pix_idx_t'(wr_count)));
                    wr_count++;
                end
            end
            hold_pend = grad_wr && !grad_gnt;
            held_addr = grad_addr;
            held_word = got_word;
        end
        reset_q = reset;
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic run_image(input string label);
        int cycles;
        // four reset cycles, released on a falling edge
        reset = 1'b1;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (done !== 1'b1) begin
            if (cycles >= DONE_LIMIT) begin
                fail_now($sformatf("%s image: done did not rise within %0d cycles",
                    label, DONE_LIMIT));
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        // done has to stay up, the checker watches it
        repeat (TAIL_CYCLES) @(negedge clk);
        if (wr_count != IMG_PIX) begin
            fail_now($sformatf("%s image: %0d words written instead of %0d",
                label, wr_count, IMG_PIX));
        end else if (rd_count != IMG_PIX) begin
            fail_now($sformatf("%s image: %0d pixels read instead of %0d",
                label, rd_count, IMG_PIX));
        end else begin
            $display("%s image: %0d words in %0d cycles", label, wr_count, cycles);
        end
    endtask

    initial begin
        reset    = 1'b1;
        img_di   = '0;
        grad_gnt = 1'b0;
        seed     = 7867;
        for (int i = 0; i < IMG_PIX; i++) begin
            img_mem[i] = pix_t'($random(seed));
        end
        run_image("random");
        // checkerboard drives both differences to the extremes
        for (int i = 0; i < IMG_PIX; i++) begin
            img_mem[i] = (((i / IMG_W) + (i % IMG_W)) % 2 != 0) ? 8'd255 : 8'd0;
        end
        run_image("checkerboard");
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- vlog.f
verilog/ig_pkg.sv
verilog/ig_ifs.sv
verilog/ig_ctrl.sv
verilog/ig_fetch.sv
verilog/ig_line_buf.sv
verilog/ig_grad_unit.sv
verilog/ig_top.sv
dv/ig_tb.sv

//--- Bender.yml
package:
  name: ig_gradient

sources:
  - verilog/ig_pkg.sv
  - verilog/ig_ifs.sv
  - verilog/ig_ctrl.sv
  - verilog/ig_fetch.sv
  - verilog/ig_line_buf.sv
  - verilog/ig_grad_unit.sv
  - verilog/ig_top.sv
  - target: simulation
    files:
      - dv/ig_tb.sv
